// ==== verification/lockstep_patterns.txt ====
// Columns: valid data(hex) irq mask(sum count irq_pending, binary) alert
// One row per clock cycle, rows 0 to 2 are under reset, LOCKSTEP_OFFSET is 2
// test reset_corrupt
0 0000 0 111 0
1 1234 1 111 0
1 ffff 0 101 0
// test enable_off
1 0001 0 000 0
1 fff0 0 000 0
1 8000 1 000 0
// test clean_wrap
1 9000 1 000 0
0 dead 0 000 0
1 c000 0 000 0
1 7fff 0 000 0
1 ffff 1 000 0
1 abcd 1 000 0
0 0000 0 000 0
1 5555 0 000 0
// test sum_corrupt
1 aaaa 0 100 0
1 0102 0 000 0
1 0304 0 000 0
0 0000 0 000 1
1 1111 0 000 0
1 2222 0 000 0
// test count_corrupt
1 3333 0 010 0
1 4444 0 000 0
0 0000 0 000 0
1 5555 0 000 1
// test irq_corrupt
1 6666 1 000 0
1 7777 0 001 0
1 8888 1 000 0
0 9999 0 000 0
1 aaaa 1 000 1
1 bbbb 0 000 0
1 cccc 1 000 0
// test adjacent_corrupt
1 dddd 0 100 0
1 eeee 1 011 0
1 ffff 0 000 0
1 0001 1 000 1
1 0002 0 000 1
0 0000 0 000 0
0 0000 0 000 0
0 0000 0 000 0

// ==== sim.f ====
+incdir+hw
hw/lockstep_pkg.sv
hw/csum_core.sv
hw/lockstep_rst_ctrl.sv
hw/lockstep_delay.sv
hw/lockstep_cmp.sv
hw/lockstep_top.sv
verification/tb_clk_gen.sv
verification/lockstep_sva.sv
verification/tb_lockstep.sv

// ==== Makefile ====
# Verilator build and run of the lockstep checker testbench

SRCS := $(shell grep -v '^+' sim.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_lockstep: sim.f $(SRCS) hw/lockstep_config.svh
	verilator --binary --timing --assert --top-module tb_lockstep -f sim.f

run: obj_dir/Vtb_lockstep
	-./obj_dir/Vtb_lockstep > sim.log 2>&1
	cat sim.log
	grep -q "^TEST RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_lockstep.sv ====
/*
  Testbench for lockstep_top. Plays the main core from a pattern file and
  checks the major alert once per cycle. Run from the project root.
  The expected alerts in the pattern file assume LOCKSTEP_OFFSET of 2.
*/
`timescale 1ns/1ps
`include "lockstep_config.svh"

module tb_lockstep;
  import lockstep_pkg::*;

  localparam int unsigned ResetCycles = 4;
  localparam string PatternFile = "verification/lockstep_patterns.txt";

  logic   clk_i;
  logic   rst_ni;
  logic   in_valid;
  data_t  in_data;
  logic   irq;
  data_t  main_sum;
  count_t main_count;
  logic   main_irq_pending;
  logic   alert;

  // One entry per pattern row
  logic       row_valid[$];
  data_t      row_data[$];
  logic       row_irq[$];
  logic [2:0] row_mask[$];
  logic       row_alert[$];
  string      row_test[$];

  // Main core state, same rule as the shadow core
  data_t  model_sum;
  count_t model_count;
  logic   model_irq_pending;

  int unsigned errors;
  int unsigned cycle_cnt;
  int unsigned max_cycles;

  tb_clk_gen u_clk_gen (
    .clk_o (clk_i)
  );

  lockstep_top i_lockstep_top (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .in_valid_i             (in_valid),
    .in_data_i              (in_data),
    .irq_i                  (irq),
    .main_sum_i             (main_sum),
    .main_count_i           (main_count),
    .main_irq_pending_i     (main_irq_pending),
    .alert_major_internal_o (alert)
  );

  ////////////////////////////////////////
  // Pattern file reader
  ////////////////////////////////////////

  function automatic string strip_eol(input string s);
    string t;
    t = s;
    while (t.len() > 0 && (t.getc(t.len() - 1) == 8'h0a || t.getc(t.len() - 1) == 8'h0d)) begin
      t = t.substr(0, t.len() - 2);
    end
    return t;
  endfunction

  task automatic load_patterns();
    int         fd;
    int         n;
    string      line;
    string      test_name;
    logic       v;
    data_t      d;
    logic       i;
    logic [2:0] m;
    logic       a;
    test_name = "unnamed";
    fd = $fopen(PatternFile, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s", PatternFile);
      errors++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      line = strip_eol(line);
      if (line.len() > 8 && line.substr(0, 7) == "// test ") begin
        test_name = line.substr(8, line.len() - 1);
      end else if (line.len() == 0 || line.getc(0) == "/") begin
        // Blank or comment line
      end else begin
        n = $sscanf(line, "%h %h %h %b %b", v, d, i, m, a);
        if (n != 5) begin
          $display("Pattern line could not be read: %s", line);
          errors++;
        end else begin
          row_valid.push_back(v);
          row_data.push_back(d);
          row_irq.push_back(i);
          row_mask.push_back(m);
          row_alert.push_back(a);
          row_test.push_back(test_name);
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Main core model and checks
  ////////////////////////////////////////

  // Called at the rising edge, sees the inputs of the cycle just ending
  task automatic advance_model();
    if (!rst_ni) begin
      model_sum         = '0;
      model_count       = '0;
      model_irq_pending = 1'b0;
    end else begin
      if (in_valid) begin
        model_sum   = model_sum + in_data;
        model_count = model_count + count_t'(1);
      end
      model_irq_pending = irq;
    end
  endtask

  // Masked fields are inverted to play a faulty main core
  task automatic drive_row(input int unsigned r);
    rst_ni           <= (r + 1 >= ResetCycles);
    in_valid         <= row_valid[r];
    in_data          <= row_data[r];
    irq              <= row_irq[r];
    main_sum         <= model_sum ^ {`LOCKSTEP_DATA_W{row_mask[r][2]}};
    main_count       <= model_count ^ {`LOCKSTEP_COUNT_W{row_mask[r][1]}};
    main_irq_pending <= model_irq_pending ^ row_mask[r][0];
  endtask

  task automatic check_alert(input int unsigned r);
    assert (alert === row_alert[r]) else begin
      $display("Error: %s row %0d alert expected %0b actual %0b",
               row_test[r], r, row_alert[r], alert);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus and timeout
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (max_cycles != 0 && cycle_cnt >= max_cycles) begin
      $display("Timeout after %0d cycles, the pattern rows did not finish", cycle_cnt);
      $display("Errors: %0d", errors);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    errors            = 0;
    cycle_cnt         = 0;
    max_cycles        = 0;
    rst_ni            = 1'b0;
    in_valid          = 1'b0;
    in_data           = '0;
    irq               = 1'b0;
    main_sum          = '0;
    main_count        = '0;
    main_irq_pending  = 1'b0;
    model_sum         = '0;
    model_count       = '0;
    model_irq_pending = 1'b0;
    load_patterns();
    max_cycles = row_valid.size() + `LOCKSTEP_OFFSET + 20;
    if (row_valid.size() == 0) begin
      $display("No pattern rows were loaded");
      errors++;
    end
    for (int unsigned r = 0; r < row_valid.size(); r++) begin
      @(posedge clk_i);
      advance_model();
      drive_row(r);
      // Alert settles after the edge, checked mid-cycle
      @(negedge clk_i);
      check_alert(r);
    end
    $display("Errors: %0d in %0d checked rows", errors, row_valid.size());
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/lockstep_sva.sv ====
/*
  Assertions on reset sequencing and the major alert, bound into lockstep_top.
  Only the ON enable encoding is checked by name.
*/
`timescale 1ns/1ps
`include "lockstep_config.svh"

module lockstep_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                rst_shadow_ni,
  input lockstep_pkg::mubi_t enable_cmp_i,
  input logic                alert_i
);
  import lockstep_pkg::*;

  localparam mubi_t MubiOn = mubi_t'(`LOCKSTEP_MUBI_ON);

  // No alert while the shadow core is held in reset or has just been released
  alert_off_a : assert property (@(posedge clk_i)
    (!rst_shadow_ni || !$past(rst_shadow_ni)) |-> !alert_i)
    else $error("Major alert raised before the comparison could be enabled");

  // Comparison starts only once the shadow core has been out of reset a cycle
  enable_after_release_a : assert property (@(posedge clk_i)
    (enable_cmp_i == MubiOn) |-> (rst_shadow_ni && $past(rst_shadow_ni)))
    else $error("Comparison enable ON before the shadow reset was released");

  // Shadow reset asserts only together with the main reset
  shadow_rst_fall_a : assert property (@(posedge clk_i)
    $fell(rst_shadow_ni) |-> !rst_ni)
    else $error("Shadow reset asserted while rst_ni was high");

endmodule

bind lockstep_top lockstep_sva i_lockstep_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .rst_shadow_ni (rst_shadow_n),
  .enable_cmp_i  (enable_cmp),
  .alert_i       (alert_major_internal_o)
);

// ==== verification/tb_clk_gen.sv ====
/*
  Free-running testbench clock with a 40 ns period. Starts low.
*/
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  localparam int HalfPeriodNs = 20;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

endmodule

// ==== hw/lockstep_top.sv ====
/*
  Dual-core lockstep checker. The main core sits outside, its inputs and
  outputs come in here. The shadow core runs LOCKSTEP_OFFSET cycles behind.
  Alert is combinational from registers and may pulse for single cycles.
*/
`timescale 1ns/1ps
`include "lockstep_config.svh"

module lockstep_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Main core inputs
  input  logic                 in_valid_i,
  input  lockstep_pkg::data_t  in_data_i,
  input  logic                 irq_i,
  // Main core outputs
  input  lockstep_pkg::data_t  main_sum_i,
  input  lockstep_pkg::count_t main_count_i,
  input  logic                 main_irq_pending_i,
  output logic                 alert_major_internal_o
);
  import lockstep_pkg::*;

  localparam int unsigned InW  = `LOCKSTEP_DATA_W + 2;
  localparam int unsigned OutW = `LOCKSTEP_DATA_W + `LOCKSTEP_COUNT_W + 1;

  logic            rst_shadow_n;
  mubi_t           enable_cmp;
  logic [InW-1:0]  shadow_inputs;
  logic [OutW-1:0] main_outputs_dly;
  data_t           shadow_sum;
  count_t          shadow_count;
  logic            shadow_irq_pending;

  ////////////////////////////////////////
  // Reset sequencing
  ////////////////////////////////////////

  lockstep_rst_ctrl u_rst_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rst_shadow_no (rst_shadow_n),
    .enable_cmp_o  (enable_cmp)
  );

  ////////////////////////////////////////
  // Delay lines
  ////////////////////////////////////////

  // Packed as {valid, data, irq}
  lockstep_delay #(
    .WIDTH    (InW),
    .DEPTH    (`LOCKSTEP_OFFSET),
    .RESET_EN (1'b1)
  ) u_in_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i ({in_valid_i, in_data_i, irq_i}),
    .data_o (shadow_inputs)
  );

  // One extra stage for the shadow output register
  lockstep_delay #(
    .WIDTH    (OutW),
    .DEPTH    (`LOCKSTEP_OFFSET + 1),
    .RESET_EN (1'b0)
  ) u_out_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i ({main_sum_i, main_count_i, main_irq_pending_i}),
    .data_o (main_outputs_dly)
  );

  ////////////////////////////////////////
  // Shadow core and comparison
  ////////////////////////////////////////

  csum_core u_shadow_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_shadow_n),
    .in_valid_i    (shadow_inputs[InW-1]),
    .in_data_i     (shadow_inputs[`LOCKSTEP_DATA_W:1]),
    .irq_i         (shadow_inputs[0]),
    .sum_o         (shadow_sum),
    .count_o       (shadow_count),
    .irq_pending_o (shadow_irq_pending)
  );

  lockstep_cmp u_cmp (
    .clk_i                  (clk_i),
    .enable_cmp_i           (enable_cmp),
    .shadow_sum_i           (shadow_sum),
    .shadow_count_i         (shadow_count),
    .shadow_irq_pending_i   (shadow_irq_pending),
    .main_sum_i             (main_outputs_dly[OutW-1 -: `LOCKSTEP_DATA_W]),
    .main_count_i           (main_outputs_dly[`LOCKSTEP_COUNT_W:1]),
    .main_irq_pending_i     (main_outputs_dly[0]),
    .alert_major_internal_o (alert_major_internal_o)
  );

endmodule

// ==== hw/lockstep_cmp.sv ====
/*
  Shadow output register and mismatch comparator.
  Any enable encoding other than OFF turns checking on.
  The shadow register is not reset.
*/
`timescale 1ns/1ps
`include "lockstep_config.svh"

module lockstep_cmp (
  input  logic                 clk_i,
  input  lockstep_pkg::mubi_t  enable_cmp_i,
  input  lockstep_pkg::data_t  shadow_sum_i,
  input  lockstep_pkg::count_t shadow_count_i,
  input  logic                 shadow_irq_pending_i,
  input  lockstep_pkg::data_t  main_sum_i,
  input  lockstep_pkg::count_t main_count_i,
  input  logic                 main_irq_pending_i,
  output logic                 alert_major_internal_o
);
  import lockstep_pkg::*;

  data_t  shadow_sum_q;
  count_t shadow_count_q;
  logic   shadow_irq_pending_q;
  logic   outputs_mismatch;
  logic   cmp_active;

  // One register stage, matched by the extra stage on the main outputs
  always_ff @(posedge clk_i) begin
    shadow_sum_q         <= shadow_sum_i;
    shadow_count_q       <= shadow_count_i;
    shadow_irq_pending_q <= shadow_irq_pending_i;
  end

  assign outputs_mismatch = (shadow_sum_q != main_sum_i)
                          | (shadow_count_q != main_count_i)
                          | (shadow_irq_pending_q != main_irq_pending_i);

  // A corrupted enable still checks
  assign cmp_active = (enable_cmp_i != mubi_t'(`LOCKSTEP_MUBI_OFF));

  assign alert_major_internal_o = cmp_active & outputs_mismatch;

endmodule

// ==== hw/lockstep_delay.sv ====
/*
  Shift-register delay line, DEPTH stages of WIDTH bits, DEPTH of 1 or more.
  With RESET_EN clear the stages have no reset and rst_ni is ignored.
*/
`timescale 1ns/1ps

module lockstep_delay #(
  parameter int unsigned WIDTH    = 8,
  parameter int unsigned DEPTH    = 2,
  parameter bit          RESET_EN = 1'b1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o
);

  // Stage 0 takes the input, the last stage drives the output
  logic [DEPTH-1:0][WIDTH-1:0] stage_q;

  if (RESET_EN) begin : g_reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        stage_q <= '0;
      end else begin
        stage_q[0] <= data_i;
        for (int unsigned i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end
  end else begin : g_no_reset
    always_ff @(posedge clk_i) begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[DEPTH-1];

endmodule

// ==== hw/lockstep_rst_ctrl.sv ====
/*
  Shadow reset and comparison enable sequencing.
  Shadow reset asserts with rst_ni and is released synchronously after
  LOCKSTEP_OFFSET edges. Comparison turns on one edge later.
*/
`timescale 1ns/1ps
`include "lockstep_config.svh"

module lockstep_rst_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  output logic                rst_shadow_no,
  output lockstep_pkg::mubi_t enable_cmp_o
);
  import lockstep_pkg::*;

  localparam offset_cnt_t CntLast = offset_cnt_t'(`LOCKSTEP_OFFSET - 1);

  offset_cnt_t rst_shadow_cnt_q;
  mubi_t       rst_shadow_set_d;
  mubi_t       rst_shadow_set_q;
  mubi_t       enable_cmp_q;

  ////////////////////////////////////////
  // Offset counter
  ////////////////////////////////////////

  // Counts from reset release and stops at the last value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_shadow_cnt_q <= '0;
    end else if (rst_shadow_cnt_q != CntLast) begin
      rst_shadow_cnt_q <= rst_shadow_cnt_q + offset_cnt_t'(1);
    end
  end

  ////////////////////////////////////////
  // Shadow set and compare enable
  ////////////////////////////////////////

  assign rst_shadow_set_d =
    (rst_shadow_cnt_q >= CntLast) ? mubi_t'(`LOCKSTEP_MUBI_ON) : mubi_t'(`LOCKSTEP_MUBI_OFF);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_shadow_set_q <= mubi_t'(`LOCKSTEP_MUBI_OFF);
      enable_cmp_q     <= mubi_t'(`LOCKSTEP_MUBI_OFF);
    end else begin
      rst_shadow_set_q <= rst_shadow_set_d;
      enable_cmp_q     <= rst_shadow_set_q;
    end
  end

  // Bit 0 is 1 for ON and 0 for OFF
  assign rst_shadow_no = rst_shadow_set_q[0];
  assign enable_cmp_o  = enable_cmp_q;

endmodule

// ==== hw/csum_core.sv ====
/*
  Checksum core used as the lockstepped copy. Sum and count wrap silently.
  All outputs are registered and reset to zero.
*/
`timescale 1ns/1ps

module csum_core (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 in_valid_i,
  input  lockstep_pkg::data_t  in_data_i,
  input  logic                 irq_i,
  output lockstep_pkg::data_t  sum_o,
  output lockstep_pkg::count_t count_o,
  output logic                 irq_pending_o
);
  import lockstep_pkg::*;

  data_t  sum_q;
  count_t count_q;
  logic   irq_pending_q;

  // Accumulate only on valid words, hold otherwise
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q   <= '0;
      count_q <= '0;
    end else if (in_valid_i) begin
      sum_q   <= sum_q + in_data_i;
      count_q <= count_q + count_t'(1);
    end
  end

  // Interrupt request is a level, just registered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_pending_q <= 1'b0;
    end else begin
      irq_pending_q <= irq_i;
    end
  end

  assign sum_o         = sum_q;
  assign count_o       = count_q;
  assign irq_pending_o = irq_pending_q;

endmodule

// ==== hw/lockstep_pkg.sv ====
/*
  Shared types of the lockstep checker, sized from lockstep_config.svh.
  The offset counter is at least one bit wide.
*/
`include "lockstep_config.svh"

package lockstep_pkg;

  // Counter only has to reach LOCKSTEP_OFFSET-1
  localparam int unsigned OffsetCntW =
    ($clog2(`LOCKSTEP_OFFSET) > 0) ? $clog2(`LOCKSTEP_OFFSET) : 1;

  // One input word, also the running sum
  typedef logic [`LOCKSTEP_DATA_W-1:0] data_t;

  // Number of accepted words
  typedef logic [`LOCKSTEP_COUNT_W-1:0] count_t;

  // Multi-bit enable
  typedef logic [`LOCKSTEP_MUBI_W-1:0] mubi_t;

  // Reset sequencing counter
  typedef logic [OffsetCntW-1:0] offset_cnt_t;

endpackage

// ==== hw/lockstep_config.svh ====
/*
  Lockstep build constants. LOCKSTEP_OFFSET must be 2 or more.
  The two enable encodings must stay LOCKSTEP_MUBI_W bits wide and complementary.
*/
`ifndef LOCKSTEP_CONFIG_SVH
`define LOCKSTEP_CONFIG_SVH

// Cycles the shadow core lags the main core
`define LOCKSTEP_OFFSET 2

// Datapath widths
`define LOCKSTEP_DATA_W 16
`define LOCKSTEP_COUNT_W 8

// Multi-bit enable encodings
`define LOCKSTEP_MUBI_W 4
`define LOCKSTEP_MUBI_ON 4'b0101
`define LOCKSTEP_MUBI_OFF 4'b1010

`endif
